/* source/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// unified memory depth, 32-bit words
`define RV_MEM_WORDS 256

// word address width into the memory
`define RV_MEM_AW 8

// byte address of the first fetch after boot
`define RV_RESET_PC 32'h0000_0000

`endif

/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // data word, also used for byte addresses
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // major opcodes understood by decode
    // anything else retires as a no-op
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // pass_b carries the U immediate for lui
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // operand source in EX
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire rv_pkg::reg_idx_t rs1_i,
    input  wire rv_pkg::reg_idx_t rs2_i,
    input  wire rv_pkg::reg_idx_t rd_i,
    input  wire logic             we_i,
    input  wire rv_pkg::word_t    wdata_i,
    output rv_pkg::word_t         rs1_data_o,
    output rv_pkg::word_t         rs2_data_o
);

    rv_pkg::word_t regs [32];

    // x0 cleared on reset, writes to it vanish
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            regs[0] <= '0;
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // WB write seen by ID in the same cycle, never for x0
    assign rs1_data_o = (we_i && (rd_i != '0) && (rd_i == rs1_i)) ? wdata_i : regs[rs1_i];
    assign rs2_data_o = (we_i && (rd_i != '0) && (rd_i == rs2_i)) ? wdata_i : regs[rs2_i];

    // x0 on either port, even right after a write aimed at it
    a_x0_zero_rs1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs1_i == '0) |-> (rs1_data_o == '0));

    a_x0_zero_rs2: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs2_i == '0) |-> (rs2_data_o == '0));

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire rv_pkg::reg_idx_t id_rs1_i,
    input  wire rv_pkg::reg_idx_t id_rs2_i,
    input  wire rv_pkg::reg_idx_t ex_rs1_i,
    input  wire rv_pkg::reg_idx_t ex_rs2_i,
    input  wire rv_pkg::reg_idx_t ex_rd_i,
    input  wire logic             ex_is_load_i,
    input  wire rv_pkg::reg_idx_t mem_rd_i,
    input  wire logic             mem_wr_i,
    input  wire rv_pkg::reg_idx_t wb_rd_i,
    input  wire logic             wb_wr_i,
    output rv_pkg::fwd_sel_e      fwd_a_o,
    output rv_pkg::fwd_sel_e      fwd_b_o,
    output logic                  stall_o
);

    // youngest producer wins, so MEM is checked first
    function automatic rv_pkg::fwd_sel_e pick_src(input rv_pkg::reg_idx_t rs);
        if (rs == '0) begin
            return rv_pkg::FWD_NONE;
        end
        if (mem_wr_i && (mem_rd_i == rs)) begin
            return rv_pkg::FWD_MEM;
        end
        if (wb_wr_i && (wb_rd_i == rs)) begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_NONE;
    endfunction

    // MEM and WB flags feed the selects too
    always_comb begin
        fwd_a_o = pick_src(ex_rs1_i);
        fwd_b_o = pick_src(ex_rs2_i);
    end

    // load data only exists after MEM, so hold ID one cycle
    // a load to x0 produces nothing to wait for
    assign stall_o = ex_is_load_i && (ex_rd_i != '0) &&
                     ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

endmodule

`default_nettype wire

/* source/datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module rv_core_datapath (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              boot_i,
    input  wire logic              fetch_gnt_i,
    input  wire logic              data_gnt_i,
    input  wire rv_pkg::word_t     mem_rdata_i,
    input  wire rv_pkg::fwd_sel_e  fwd_a_i,
    input  wire rv_pkg::fwd_sel_e  fwd_b_i,
    input  wire logic              stall_i,
    output logic                   fetch_req_o,
    output rv_pkg::word_t          fetch_addr_o,
    output logic                   data_req_o,
    output logic                   data_we_o,
    output rv_pkg::word_t          data_addr_o,
    output rv_pkg::word_t          data_wdata_o,
    output rv_pkg::reg_idx_t       id_rs1_o,
    output rv_pkg::reg_idx_t       id_rs2_o,
    output rv_pkg::reg_idx_t       ex_rs1_o,
    output rv_pkg::reg_idx_t       ex_rs2_o,
    output rv_pkg::reg_idx_t       ex_rd_o,
    output rv_pkg::reg_idx_t       mem_rd_o,
    output rv_pkg::reg_idx_t       wb_rd_o,
    output logic                   ex_is_load_o,
    output logic                   mem_wr_o,
    output logic                   wb_wr_o,
    output logic                   retire_valid_o,
    output rv_pkg::reg_idx_t       retire_rd_o,
    output rv_pkg::word_t          retire_data_o
);

    // IF and IF/ID
    rv_pkg::word_t    pc_q;
    logic             if_id_valid;
    rv_pkg::word_t    if_id_instr, if_id_pc;
    // ID decode results
    rv_pkg::opcode_e  id_opcode;
    logic [2:0]       id_funct3;
    rv_pkg::word_t    id_rs1_data, id_rs2_data, id_imm;
    rv_pkg::alu_op_e  id_alu_op;
    logic             id_use_imm, id_use_rs1, id_use_rs2;
    logic             id_wr, id_load, id_store, id_branch;
    // ID/EX
    logic             ex_valid;
    rv_pkg::word_t    ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    rv_pkg::reg_idx_t ex_rs1, ex_rs2, ex_rd;
    rv_pkg::alu_op_e  ex_alu_op;
    logic             ex_use_imm, ex_wr, ex_load, ex_store, ex_branch, ex_bne;
    // EX stage
    rv_pkg::word_t    ex_a, ex_b_fwd, ex_b, ex_alu;
    logic             ex_taken;
    // EX/MEM
    logic             mem_valid, mem_wr, mem_load, mem_store;
    rv_pkg::reg_idx_t mem_rd;
    rv_pkg::word_t    mem_alu, mem_sdata;
    // MEM/WB
    logic             wb_valid, wb_wr;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;
    // whole pipe freezes if MEM loses the port
    logic             mem_wait;

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_e sel,
                                              input rv_pkg::word_t reg_val);
        case (sel)
            rv_pkg::FWD_MEM: return mem_alu;
            rv_pkg::FWD_WB:  return wb_data;
            default:         return reg_val;
        endcase
    endfunction

    // fetch: PC straight onto the shared port
    assign fetch_req_o  = !boot_i;
    assign fetch_addr_o = pc_q;

    // decode
    assign id_opcode = rv_pkg::opcode_e'(if_id_instr[6:0]);
    assign id_funct3 = if_id_instr[14:12];

    always_comb begin
        id_alu_op  = rv_pkg::ALU_ADD;
        id_imm     = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
        id_use_imm = 1'b1;
        id_use_rs1 = 1'b1;
        id_use_rs2 = 1'b0;
        id_wr      = 1'b0;
        id_load    = 1'b0;
        id_store   = 1'b0;
        id_branch  = 1'b0;
        case (id_opcode)
            rv_pkg::OP_LUI: begin
                id_alu_op  = rv_pkg::ALU_PASS_B;
                id_imm     = {if_id_instr[31:12], 12'h000};
                id_use_rs1 = 1'b0;
                id_wr      = 1'b1;
            end
            rv_pkg::OP_IMM, rv_pkg::OP_REG: begin
                id_use_imm = (id_opcode == rv_pkg::OP_IMM);
                id_use_rs2 = (id_opcode == rv_pkg::OP_REG);
                id_wr      = 1'b1;
                case (id_funct3)
                    3'b000: id_alu_op = (id_use_rs2 && if_id_instr[30]) ?
                                        rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b010: id_alu_op = rv_pkg::ALU_SLT;
                    3'b100: id_alu_op = rv_pkg::ALU_XOR;
                    3'b110: id_alu_op = rv_pkg::ALU_OR;
                    3'b111: id_alu_op = rv_pkg::ALU_AND;
                    // shifts and sltu not built
                    default: id_wr = 1'b0;
                endcase
            end
            rv_pkg::OP_LOAD: begin
                id_load = 1'b1;
                id_wr   = 1'b1;
            end
            rv_pkg::OP_STORE: begin
                id_imm     = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
                id_store   = 1'b1;
                id_use_rs2 = 1'b1;
            end
            rv_pkg::OP_BRANCH: begin
                id_imm     = {{20{if_id_instr[31]}}, if_id_instr[7], if_id_instr[30:25],
                              if_id_instr[11:8], 1'b0};
                // beq and bne only
                id_branch  = (id_funct3[2:1] == 2'b00);
                id_use_rs2 = 1'b1;
            end
            default: id_use_rs1 = 1'b0;
        endcase
    end

    // unused sources masked so they cannot cause a false stall
    assign id_rs1_o = (if_id_valid && id_use_rs1) ? if_id_instr[19:15] : '0;
    assign id_rs2_o = (if_id_valid && id_use_rs2) ? if_id_instr[24:20] : '0;

    regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (if_id_instr[19:15]),
        .rs2_i      (if_id_instr[24:20]),
        .rd_i       (wb_rd),
        .we_i       (wb_wr_o),
        .wdata_i    (wb_data),
        .rs1_data_o (id_rs1_data),
        .rs2_data_o (id_rs2_data)
    );

    // EX: operands, ALU, branch compare
    // forwarded MEM and WB values also drive the operands
    always_comb begin
        ex_a     = fwd_mux(fwd_a_i, ex_rs1_data);
        ex_b_fwd = fwd_mux(fwd_b_i, ex_rs2_data);
    end
    assign ex_b     = ex_use_imm ? ex_imm : ex_b_fwd;

    always_comb begin
        case (ex_alu_op)
            rv_pkg::ALU_ADD: ex_alu = ex_a + ex_b;
            rv_pkg::ALU_SUB: ex_alu = ex_a - ex_b;
            rv_pkg::ALU_AND: ex_alu = ex_a & ex_b;
            rv_pkg::ALU_OR:  ex_alu = ex_a | ex_b;
            rv_pkg::ALU_XOR: ex_alu = ex_a ^ ex_b;
            rv_pkg::ALU_SLT: ex_alu = {31'b0, $signed(ex_a) < $signed(ex_b)};
            default:         ex_alu = ex_b;
        endcase
    end

    // bne inverts the equality test
    assign ex_taken = ex_valid && ex_branch && ((ex_a == ex_b_fwd) != ex_bne);

    // MEM: data side of the shared port
    assign data_req_o   = mem_valid && (mem_load || mem_store);
    assign data_we_o    = mem_valid && mem_store;
    assign data_addr_o  = mem_alu;
    assign data_wdata_o = mem_sdata;
    assign mem_wait     = data_req_o && !data_gnt_i;

    // valid bits and PC
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || boot_i) begin
            pc_q        <= `RV_RESET_PC;
            if_id_valid <= 1'b0;
            ex_valid    <= 1'b0;
            mem_valid   <= 1'b0;
            wb_valid    <= 1'b0;
        end else if (!mem_wait) begin
            wb_valid  <= mem_valid;
            mem_valid <= ex_valid;
            if (ex_taken) begin
                // kill the two younger ones
                pc_q        <= ex_pc + ex_imm;
                if_id_valid <= 1'b0;
                ex_valid    <= 1'b0;
            end else if (stall_i) begin
                // IF/ID and PC hold, bubble into EX
                ex_valid <= 1'b0;
            end else begin
                ex_valid    <= if_id_valid;
                // fetch lost to a data access: bubble, PC held
                if_id_valid <= fetch_gnt_i;
                if (fetch_gnt_i) begin
                    pc_q <= pc_q + 32'd4;
                end
            end
        end
    end

    // payload registers
    always_ff @(posedge clk_i) begin
        if (!mem_wait) begin
            if (fetch_gnt_i && !stall_i) begin
                if_id_instr <= mem_rdata_i;
                if_id_pc    <= pc_q;
            end
            if (!stall_i) begin
                ex_pc       <= if_id_pc;
                ex_rs1_data <= id_rs1_data;
                ex_rs2_data <= id_rs2_data;
                ex_imm      <= id_imm;
                ex_rs1      <= if_id_instr[19:15];
                ex_rs2      <= if_id_instr[24:20];
                ex_rd       <= if_id_instr[11:7];
                ex_alu_op   <= id_alu_op;
                ex_use_imm  <= id_use_imm;
                ex_wr       <= id_wr;
                ex_load     <= id_load;
                ex_store    <= id_store;
                ex_branch   <= id_branch;
                ex_bne      <= id_funct3[0];
            end
            mem_rd    <= ex_rd;
            mem_wr    <= ex_wr;
            mem_load  <= ex_load;
            mem_store <= ex_store;
            mem_alu   <= ex_alu;
            mem_sdata <= ex_b_fwd;
            wb_rd     <= mem_rd;
            wb_wr     <= mem_wr;
            // loads take the shared read word
            wb_data   <= mem_load ? mem_rdata_i : mem_alu;
        end
    end

    // hazard unit view
    assign ex_rs1_o     = ex_rs1;
    assign ex_rs2_o     = ex_rs2;
    assign ex_rd_o      = ex_rd;
    assign ex_is_load_o = ex_valid && ex_load;
    assign mem_rd_o     = mem_rd;
    assign mem_wr_o     = mem_valid && mem_wr;
    assign wb_rd_o      = wb_rd;
    assign wb_wr_o      = wb_valid && wb_wr;

    // retire trace, x0 writes stay out of it
    assign retire_valid_o = wb_wr_o && (wb_rd != '0);
    assign retire_rd_o    = wb_rd;
    assign retire_data_o  = wb_data;

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module mem_arbiter (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            boot_req_i,
    input  wire rv_pkg::word_t   boot_addr_i,
    input  wire rv_pkg::word_t   boot_wdata_i,
    input  wire logic            data_req_i,
    input  wire logic            data_we_i,
    input  wire rv_pkg::word_t   data_addr_i,
    input  wire rv_pkg::word_t   data_wdata_i,
    input  wire logic            fetch_req_i,
    input  wire rv_pkg::word_t   fetch_addr_i,
    output logic                 boot_gnt_o,
    output logic                 data_gnt_o,
    output logic                 fetch_gnt_o,
    output logic                 mem_en_o,
    output logic                 mem_we_o,
    output logic [`RV_MEM_AW-1:0] mem_addr_o,
    output rv_pkg::word_t        mem_wdata_o
);

    rv_pkg::word_t sel_addr;
    // saturating run length of refused fetches
    logic [1:0]    fetch_deny_cnt;

    // fixed priority: loader, data, fetch
    assign boot_gnt_o  = boot_req_i;
    assign data_gnt_o  = data_req_i && !boot_req_i;
    assign fetch_gnt_o = fetch_req_i && !boot_req_i && !data_req_i;
    assign mem_en_o    = boot_req_i || data_req_i || fetch_req_i;
    // loader only ever writes
    assign mem_we_o    = boot_gnt_o || (data_gnt_o && data_we_i);

    always_comb begin
        sel_addr    = fetch_addr_i;
        mem_wdata_o = data_wdata_i;
        if (boot_req_i) begin
            sel_addr    = boot_addr_i;
            mem_wdata_o = boot_wdata_i;
        end else if (data_req_i) begin
            sel_addr = data_addr_i;
        end
    end

    // byte address in, word index out
    assign mem_addr_o = sel_addr[`RV_MEM_AW+1:2];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_deny_cnt <= 2'd0;
        end else if (fetch_req_i && !fetch_gnt_o) begin
            if (fetch_deny_cnt != 2'd3) begin
                fetch_deny_cnt <= fetch_deny_cnt + 2'd1;
            end
        end else begin
            fetch_deny_cnt <= 2'd0;
        end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({boot_gnt_o, data_gnt_o, fetch_gnt_o}));

    a_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_en_o |-> (sel_addr[1:0] == 2'b00));

    // data traffic never shuts fetch out for long once running
    a_no_starve: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !boot_req_i |-> (fetch_deny_cnt <= 2'd2));

endmodule

`default_nettype wire

/* source/unified_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module unified_mem #(
    parameter int DEPTH_WORDS = `RV_MEM_WORDS
) (
    input  wire logic                 clk_i,
    input  wire logic                 en_i,
    input  wire logic                 we_i,
    input  wire logic [`RV_MEM_AW-1:0] addr_i,
    input  wire rv_pkg::word_t        wdata_i,
    output rv_pkg::word_t             rdata_o
);

    rv_pkg::word_t mem [DEPTH_WORDS];

    // write lands on the edge
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // read answers in the grant cycle
    assign rdata_o = mem[addr_i];

endmodule

`default_nettype wire

/* source/core_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module core_top (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           boot_i,
    input  wire rv_pkg::word_t  boot_addr_i,
    input  wire rv_pkg::word_t  boot_wdata_i,
    output logic                retire_valid_o,
    output rv_pkg::reg_idx_t    retire_rd_o,
    output rv_pkg::word_t       retire_data_o
);

    // shared port
    logic                  fetch_req, fetch_gnt, data_req, data_gnt, data_we;
    rv_pkg::word_t         fetch_addr, data_addr, data_wdata, mem_rdata, mem_wdata;
    logic                  mem_en, mem_we;
    logic [`RV_MEM_AW-1:0] mem_addr;
    // hazard handshake
    rv_pkg::reg_idx_t      id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
    logic                  ex_is_load, mem_wr, wb_wr, stall;
    rv_pkg::fwd_sel_e      fwd_a, fwd_b;

    rv_core_datapath u_datapath (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .boot_i         (boot_i),
        .fetch_gnt_i    (fetch_gnt),
        .data_gnt_i     (data_gnt),
        .mem_rdata_i    (mem_rdata),
        .fwd_a_i        (fwd_a),
        .fwd_b_i        (fwd_b),
        .stall_i        (stall),
        .fetch_req_o    (fetch_req),
        .fetch_addr_o   (fetch_addr),
        .data_req_o     (data_req),
        .data_we_o      (data_we),
        .data_addr_o    (data_addr),
        .data_wdata_o   (data_wdata),
        .id_rs1_o       (id_rs1),
        .id_rs2_o       (id_rs2),
        .ex_rs1_o       (ex_rs1),
        .ex_rs2_o       (ex_rs2),
        .ex_rd_o        (ex_rd),
        .mem_rd_o       (mem_rd),
        .wb_rd_o        (wb_rd),
        .ex_is_load_o   (ex_is_load),
        .mem_wr_o       (mem_wr),
        .wb_wr_o        (wb_wr),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    hazard_unit u_hazard (
        .id_rs1_i     (id_rs1),
        .id_rs2_i     (id_rs2),
        .ex_rs1_i     (ex_rs1),
        .ex_rs2_i     (ex_rs2),
        .ex_rd_i      (ex_rd),
        .ex_is_load_i (ex_is_load),
        .mem_rd_i     (mem_rd),
        .mem_wr_i     (mem_wr),
        .wb_rd_i      (wb_rd),
        .wb_wr_i      (wb_wr),
        .fwd_a_o      (fwd_a),
        .fwd_b_o      (fwd_b),
        .stall_o      (stall)
    );

    // loader has no handshake, boot_i is its request
    mem_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .boot_req_i   (boot_i),
        .boot_addr_i  (boot_addr_i),
        .boot_wdata_i (boot_wdata_i),
        .data_req_i   (data_req),
        .data_we_i    (data_we),
        .data_addr_i  (data_addr),
        .data_wdata_i (data_wdata),
        .fetch_req_i  (fetch_req),
        .fetch_addr_i (fetch_addr),
        .boot_gnt_o   (),
        .data_gnt_o   (data_gnt),
        .fetch_gnt_o  (fetch_gnt),
        .mem_en_o     (mem_en),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata)
    );

    unified_mem #(
        .DEPTH_WORDS (`RV_MEM_WORDS)
    ) u_mem (
        .clk_i   (clk_i),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

/* tests/tb_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

    // program length, program, retire count, retire records
    localparam int VEC_WORDS = 256;

    logic             clk;
    logic             rst_n;
    logic             boot;
    rv_pkg::word_t    boot_addr;
    rv_pkg::word_t    boot_wdata;
    logic             retire_valid;
    rv_pkg::reg_idx_t retire_rd;
    rv_pkg::word_t    retire_data;

    logic [39:0] vec_mem [VEC_WORDS];
    int          prog_len;
    int          exp_count;
    int          seen;
    int          idx;
    int          cycle_cnt;
    int          cycle_limit;
    // error counters, all reported in the closing line
    int          value_errs;
    int          extra_errs;
    int          missing_errs;
    int          file_errs;

    core_top dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .boot_i         (boot),
        .boot_addr_i    (boot_addr),
        .boot_wdata_i   (boot_wdata),
        .retire_valid_o (retire_valid),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // one retire against the next record, in program order
    task automatic check_retire();
        logic [39:0]      rec;
        rv_pkg::reg_idx_t exp_rd;
        rv_pkg::word_t    exp_data;
        assert (seen < exp_count) else begin
            extra_errs++;
            $display("%0t: retire of x%0d = %h came after the last expected record",
                     $time, retire_rd, retire_data);
        end
        if (seen < exp_count) begin
            // rd sits in the top byte of the record
            rec      = vec_mem[8'(prog_len + 2 + seen)];
            exp_rd   = rec[36:32];
            exp_data = rec[31:0];
            assert (retire_rd == exp_rd) else begin
                value_errs++;
                $display("FAIL %0t retire_rd_o expected %0d actual %0d",
                         $time, exp_rd, retire_rd);
            end
            assert (retire_data == exp_data) else begin
                value_errs++;
                $display("FAIL %0t retire_data_o expected %h actual %h",
                         $time, exp_data, retire_data);
            end
            seen++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        // loader owns the memory from time zero, so fetch stays off
        boot         = 1'b1;
        boot_addr    = '0;
        boot_wdata   = '0;
        seen         = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        value_errs   = 0;
        extra_errs   = 0;
        missing_errs = 0;
        file_errs    = 0;
        $readmemh("tests/core_input.mem", vec_mem);
        prog_len  = int'(vec_mem[0]);
        exp_count = int'(vec_mem[8'(prog_len + 1)]);
        assert ((prog_len > 0) && (exp_count >= 0) &&
                (prog_len + exp_count + 2 <= VEC_WORDS)) else begin
            file_errs++;
            $display("stimulus file tests/core_input.mem is missing or its lengths do not fit");
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (file_errs == 0) begin
            // one word per cycle through the loader port
            for (idx = 0; idx < prog_len; idx++) begin
                boot_addr  = 32'(idx) << 2;
                boot_wdata = vec_mem[8'(idx + 1)][31:0];
                @(posedge clk);
                #1;
            end
            boot = 1'b0;
            // program ends in a branch-to-self, run on to catch stray retires
            cycle_limit = 8 * exp_count + prog_len + 40;
            while (cycle_cnt < cycle_limit) begin
                // mid-cycle, retire outputs are settled
                @(negedge clk);
                if (retire_valid) begin
                    check_retire();
                end
                cycle_cnt++;
            end
            assert (seen == exp_count) else begin
                missing_errs = exp_count - seen;
                $display("%0t: only %0d of %0d expected retires seen before the cycle limit",
                         $time, seen, exp_count);
            end
        end
        $display("errors: value=%0d extra=%0d missing=%0d file=%0d",
                 value_errs, extra_errs, missing_errs, file_errs);
        if (value_errs + extra_errs + missing_errs + file_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/core_input.mem */
// one hex word per line: program length, program words, retire count,
// then retire records {rd, value} with rd in the top two digits
0000001D // 29 program words
123450B7 // 00 lui  x1, 0x12345
FFF00113 // 04 addi x2, x0, -1
6870C193 // 08 xori x3, x1, 0x687   x1 from WB
0F01F213 // 0c andi x4, x3, 0x0f0   x3 from MEM
50526293 // 10 ori  x5, x4, 0x505
00012313 // 14 slti x6, x2, 0
406283B3 // 18 sub  x7, x5, x6      MEM and WB at once
00338433 // 1c add  x8, x7, x3
007474B3 // 20 and  x9, x8, x7
0064E533 // 24 or   x10, x9, x6
005545B3 // 28 xor  x11, x10, x5
0025A633 // 2c slt  x12, x11, x2
00508013 // 30 addi x0, x1, 5       never retires
00B006B3 // 34 add  x13, x0, x11    x0 must read zero
10000713 // 38 addi x14, x0, 0x100
00372023 // 3c sw   x3, 0(x14)
00072783 // 40 lw   x15, 0(x14)
00178813 // 44 addi x16, x15, 1     load-use stall
00378663 // 48 beq  x15, x3, +12    taken
11100893 // 4c addi x17, x0, 0x111  wrong path
22200893 // 50 addi x17, x0, 0x222  wrong path
00F81663 // 54 bne  x16, x15, +12   taken
33300913 // 58 addi x18, x0, 0x333  wrong path
44400913 // 5c addi x18, x0, 0x444  wrong path
00308463 // 60 beq  x1, x3, +8      not taken
7FF00993 // 64 addi x19, x0, 0x7ff
00000063 // 68 beq  x0, x0, 0       spin here
00000013 // 6c nop
00000013 // 70 nop
00000011 // 17 retires
0112345000
02FFFFFFFF
0312345687
0400000080
0500000585
0600000001
0700000584
0812345C0B
0900000400
0A00000401
0B00000184
0C00000000
0D00000184
0E00000100
0F12345687
1012345688
13000007FF

/* flist.f */
+incdir+source
source/rv_pkg.sv
source/regfile.sv
source/hazard_unit.sv
source/datapath.sv
source/mem_arbiter.sv
source/unified_mem.sv
source/core_top.sv
tests/tb_core_top.sv

/* Makefile */
VERILATOR  := verilator
TB_TOP     := tb_core_top
RTL_TOP    := core_top
FLIST      := flist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
